//--- aluPkg.sv
package aluPkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  parameter int defaultDataWidth = 8;   // Data word width
  parameter int defaultRegCount  = 16;  // Register file depth

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Instruction opcodes, 5-bit field as in the instruction word
  typedef enum logic [4:0] {
    opNop = 5'h00,
    opAdd = 5'h01,
    opSub = 5'h02,
    opAnd = 5'h03,
    opOr  = 5'h04,
    opXor = 5'h05,
    opShl = 5'h06,
    opShr = 5'h07,
    opCmp = 5'h08,
    opLdi = 5'h09
  } aluOp_e;

  // Sequencer phases
  typedef enum logic [1:0] {
    phIdle  = 2'd0,
    phRead  = 2'd1,  // Register file read
    phExec  = 2'd2,  // ALU result saved
    phWrite = 2'd3   // Write-back
  } phase_e;

endpackage

//--- operandIf.sv
`timescale 1ns/1ps

// Opcode and operands shared by both ALU branches and the merger
interface operandIf #(
  parameter int dataWidth = aluPkg::defaultDataWidth
) ();

  aluPkg::aluOp_e       opcode;
  logic [dataWidth-1:0] op1;   // Register source 1
  logic [dataWidth-1:0] op2;   // Register source 2
  logic [dataWidth-1:0] imm;

  // Driven from the latched instruction and the register file
  modport issue (
    output opcode,
    output op1,
    output op2,
    output imm
  );

  // Read-only view for the ALU side
  modport user (
    input opcode,
    input op1,
    input op2,
    input imm
  );

endinterface

//--- regFile.sv
`timescale 1ns/1ps

module regFile #(
  parameter int dataWidth = aluPkg::defaultDataWidth,
  parameter int regCount  = aluPkg::defaultRegCount,
  localparam int addrWidth = $clog2(regCount)
) (
  input  logic                 clk,
  input  logic                 Reset,
  input  logic                 readEn,
  input  logic [addrWidth-1:0] addrR1,
  input  logic [addrWidth-1:0] addrR2,
  input  logic                 writeEn,
  input  logic [addrWidth-1:0] addrW,
  input  logic [dataWidth-1:0] dataIn,
  output logic [dataWidth-1:0] dataOut1,
  output logic [dataWidth-1:0] dataOut2
);

  logic [dataWidth-1:0] regs [regCount];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[addrW] <= dataIn;
    end
  end

  ////////////////////////////////////////
  // Registered read ports
  ////////////////////////////////////////

  // Both sources captured together, one cycle after readEn
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      dataOut1 <= '0;
      dataOut2 <= '0;
    end else if (readEn) begin
      dataOut1 <= regs[addrR1];
      dataOut2 <= regs[addrR2];
    end
  end

  // Read and write never overlap within one instruction
  noReadOnWrite: assert property (@(posedge clk) disable iff (Reset)
    writeEn |-> !readEn && $past(readEn, 2));

endmodule

//--- arithUnit.sv
`timescale 1ns/1ps

module arithUnit #(
  parameter int dataWidth = aluPkg::defaultDataWidth
) (
  operandIf.user               ops,
  output logic [dataWidth-1:0] sum,
  output logic                 carry,
  output logic                 overflow
);

  logic                 sub;       // Subtract mode, also carry-in
  logic [dataWidth-1:0] opB;
  logic [dataWidth-2:0] lowSum;
  logic                 carryLow;  // Carry into the top bit
  logic                 topSum;

  // opCmp computes the same difference as opSub
  assign sub = (ops.opcode == aluPkg::opSub) || (ops.opcode == aluPkg::opCmp);

  assign opB = ops.op2 ^ {dataWidth{sub}};  // Ones complement for subtract

  ////////////////////////////////////////
  // Adder split at the top bit
  ////////////////////////////////////////

  assign {carryLow, lowSum} = {1'b0, ops.op1[dataWidth-2:0]}
                            + {1'b0, opB[dataWidth-2:0]}
                            + {{(dataWidth-1){1'b0}}, sub};

  assign {carry, topSum} = {1'b0, ops.op1[dataWidth-1]}
                         + {1'b0, opB[dataWidth-1]}
                         + {1'b0, carryLow};

  assign sum = {topSum, lowSum};

  // Signed overflow from the top two carries
  assign overflow = carry ^ carryLow;

endmodule

//--- logicUnit.sv
`timescale 1ns/1ps

module logicUnit #(
  parameter int dataWidth = aluPkg::defaultDataWidth
) (
  operandIf.user               ops,
  output logic [dataWidth-1:0] logicOut,
  output logic                 shiftCarry
);

  localparam int shiftWidth = $clog2(dataWidth);

  logic [shiftWidth-1:0] shamt;

  assign shamt = ops.op2[shiftWidth-1:0];  // Low bits of operand two

  always_comb begin
    logicOut   = '0;
    shiftCarry = 1'b0;
    case (ops.opcode)
      aluPkg::opAnd: logicOut = ops.op1 & ops.op2;
      aluPkg::opOr:  logicOut = ops.op1 | ops.op2;
      aluPkg::opXor: logicOut = ops.op1 ^ ops.op2;
      aluPkg::opShl: begin
        logicOut   = ops.op1 << shamt;
        shiftCarry = ops.op1[dataWidth-1];  // Top bit of op1
      end
      aluPkg::opShr: begin
        logicOut   = ops.op1 >> shamt;
        shiftCarry = ops.op1[0];            // Bottom bit of op1
      end
      default: begin
        logicOut   = '0;
        shiftCarry = 1'b0;
      end
    endcase
  end

endmodule

//--- resultMerge.sv
`timescale 1ns/1ps

module resultMerge #(
  parameter int dataWidth = aluPkg::defaultDataWidth
) (
  input  logic                 clk,
  input  logic                 Reset,
  input  logic                 aluSave,
  operandIf.user               ops,
  input  logic [dataWidth-1:0] sum,
  input  logic                 carry,
  input  logic [dataWidth-1:0] logicOut,
  input  logic                 shiftCarry,
  output logic [dataWidth-1:0] result,
  output logic                 zFlag,
  output logic                 cFlag
);

  logic [dataWidth-1:0] nextResult;
  logic                 nextZ;
  logic                 nextC;

  ////////////////////////////////////////
  // Branch select and flag rules
  ////////////////////////////////////////

  always_comb begin
    nextResult = result;  // Hold unless the opcode updates it
    nextZ      = zFlag;
    nextC      = cFlag;
    case (ops.opcode)
      aluPkg::opAdd, aluPkg::opSub: begin
        nextResult = sum;
        nextZ      = (sum == '0);
        nextC      = carry;
      end
      aluPkg::opCmp: begin
        // Flags only
        nextZ = (sum == '0);
        nextC = carry;
      end
      aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor: begin
        nextResult = logicOut;
        nextZ      = (logicOut == '0);  // Carry kept
      end
      aluPkg::opShl, aluPkg::opShr: begin
        nextResult = logicOut;
        nextZ      = (logicOut == '0);
        nextC      = shiftCarry;
      end
      aluPkg::opLdi: nextResult = ops.imm;
      default: nextResult = result;    // opNop
    endcase
  end

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      result <= '0;
      zFlag  <= 1'b0;
      cFlag  <= 1'b0;
    end else if (aluSave) begin
      result <= nextResult;
      zFlag  <= nextZ;
      cFlag  <= nextC;
    end
  end

  // Flags move only on the save edge
  flagsHeld: assert property (@(posedge clk) disable iff (Reset)
    !$past(aluSave) |-> $stable(zFlag) && $stable(cFlag));

endmodule

//--- execSequencer.sv
`timescale 1ns/1ps

module execSequencer #(
  parameter int dataWidth = aluPkg::defaultDataWidth,
  parameter int regCount  = aluPkg::defaultRegCount,
  localparam int addrWidth = $clog2(regCount)
) (
  input  logic                 clk,
  input  logic                 Reset,
  input  logic                 start,
  input  aluPkg::aluOp_e       opcode,
  input  logic [addrWidth-1:0] destin,
  input  logic [addrWidth-1:0] source1,
  input  logic [addrWidth-1:0] source2,
  input  logic [dataWidth-1:0] imm,
  output logic                 busy,
  output logic                 done,
  output logic                 readEn,
  output logic                 aluSave,
  output logic                 writeEn,
  output aluPkg::aluOp_e       curOp,
  output logic [addrWidth-1:0] curDestin,
  output logic [addrWidth-1:0] curSrc1,
  output logic [addrWidth-1:0] curSrc2,
  output logic [dataWidth-1:0] curImm
);

  aluPkg::phase_e phase;
  logic           accept;

  assign accept = start && (phase == aluPkg::phIdle);  // Start ignored while busy

  ////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      phase <= aluPkg::phIdle;
      curOp <= aluPkg::opNop;
    end else begin
      case (phase)
        aluPkg::phIdle:  if (accept) phase <= aluPkg::phRead;
        aluPkg::phRead:  phase <= aluPkg::phExec;
        aluPkg::phExec:  phase <= aluPkg::phWrite;
        default:         phase <= aluPkg::phIdle;
      endcase
      if (accept) curOp <= opcode;
    end
  end

  // Instruction fields
  always_ff @(posedge clk) begin
    if (accept) begin
      curDestin <= destin;
      curSrc1   <= source1;
      curSrc2   <= source2;
      curImm    <= imm;
    end
  end

  assign busy    = (phase != aluPkg::phIdle);
  assign readEn  = (phase == aluPkg::phRead);
  assign aluSave = (phase == aluPkg::phExec);
  assign done    = (phase == aluPkg::phWrite);
  assign writeEn = done && !(curOp inside {aluPkg::opCmp, aluPkg::opNop});  // No write-back

  // Done pulse ends on the third edge after the accepted start
  doneTiming: assert property (@(posedge clk) disable iff (Reset)
    done |-> $past(accept, 3));

endmodule

//--- execCore.sv
`timescale 1ns/1ps

module execCore #(
  parameter int dataWidth = aluPkg::defaultDataWidth,
  parameter int regCount  = aluPkg::defaultRegCount,
  localparam int addrWidth = $clog2(regCount)
) (
  input  logic                 clk,
  input  logic                 Reset,
  input  logic                 start,
  input  aluPkg::aluOp_e       opcode,
  input  logic [addrWidth-1:0] destin,
  input  logic [addrWidth-1:0] source1,
  input  logic [addrWidth-1:0] source2,
  input  logic [dataWidth-1:0] imm,
  output logic                 busy,
  output logic                 done,
  output logic [dataWidth-1:0] result,
  output logic                 zFlag,
  output logic                 cFlag
);

  // Sequencer strobes
  logic readEn;
  logic aluSave;
  logic writeEn;

  // Latched instruction
  aluPkg::aluOp_e       curOp;
  logic [addrWidth-1:0] curDestin;
  logic [addrWidth-1:0] curSrc1;
  logic [addrWidth-1:0] curSrc2;
  logic [dataWidth-1:0] curImm;

  // Datapath
  logic [dataWidth-1:0] regData1;
  logic [dataWidth-1:0] regData2;
  logic [dataWidth-1:0] sum;
  logic                 carry;
  logic [dataWidth-1:0] logicOut;
  logic                 shiftCarry;

  operandIf #(.dataWidth(dataWidth)) ops ();

  assign ops.opcode = curOp;
  assign ops.imm    = curImm;
  assign ops.op1    = regData1;
  assign ops.op2    = regData2;

  ////////////////////////////////////////
  // Control and storage
  ////////////////////////////////////////

  execSequencer #(.dataWidth(dataWidth), .regCount(regCount)) seqInst (
    .clk(clk), .Reset(Reset), .start(start), .opcode(opcode),
    .destin(destin), .source1(source1), .source2(source2), .imm(imm),
    .busy(busy), .done(done), .readEn(readEn), .aluSave(aluSave),
    .writeEn(writeEn), .curOp(curOp), .curDestin(curDestin),
    .curSrc1(curSrc1), .curSrc2(curSrc2), .curImm(curImm)
  );

  regFile #(.dataWidth(dataWidth), .regCount(regCount)) rfInst (
    .clk(clk), .Reset(Reset), .readEn(readEn), .addrR1(curSrc1),
    .addrR2(curSrc2), .writeEn(writeEn), .addrW(curDestin),
    .dataIn(result), .dataOut1(regData1), .dataOut2(regData2)  // Merged result written back
  );

  ////////////////////////////////////////
  // ALU branches and merger
  ////////////////////////////////////////

  arithUnit #(.dataWidth(dataWidth)) arithInst (
    .ops(ops.user), .sum(sum), .carry(carry), .overflow()
  );

  logicUnit #(.dataWidth(dataWidth)) logicInst (
    .ops(ops.user), .logicOut(logicOut), .shiftCarry(shiftCarry)
  );

  resultMerge #(.dataWidth(dataWidth)) mergeInst (
    .clk(clk), .Reset(Reset), .aluSave(aluSave), .ops(ops.user),
    .sum(sum), .carry(carry), .logicOut(logicOut), .shiftCarry(shiftCarry),
    .result(result), .zFlag(zFlag), .cFlag(cFlag)
  );

  // Write-back uses the result saved on the edge before
  writeBackOrder: assert property (@(posedge clk) disable iff (Reset)
    writeEn |-> seqInst.phase == aluPkg::phWrite && $past(aluSave));

endmodule

//--- tbModel.svh
`ifndef tbModelSvh
`define tbModelSvh

////////////////////////////////////////
// Random source
////////////////////////////////////////

logic [31:0] lfsrState = 32'hd91648d5;

function automatic logic nextBit();
  logic outBit;
  outBit    = lfsrState[0];
  lfsrState = lfsrState >> 1;
  if (outBit) lfsrState = lfsrState ^ 32'h80200003;  // Galois taps
  return outBit;
endfunction

function automatic logic [31:0] randBits(int count);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < count; i++) begin
    bits = {bits[30:0], nextBit()};  // One step per bit
  end
  return bits;
endfunction

function automatic aluPkg::aluOp_e randOp();
  logic [4:0] sel;
  sel = 5'(randBits(4) % 10);  // Ten opcodes
  return aluPkg::aluOp_e'(sel);
endfunction

function automatic logic [addrWidth-1:0] randAddr();
  return addrWidth'(randBits(addrWidth));
endfunction

function automatic logic [dataWidth-1:0] randData();
  return dataWidth'(randBits(dataWidth));
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

logic [dataWidth-1:0] modelRegs [regCount];
logic [dataWidth-1:0] modelResult;
logic                 modelZ;
logic                 modelC;

function automatic void resetModel();
  for (int r = 0; r < regCount; r++) begin
    modelRegs[r] = '0;
  end
  modelResult = '0;
  modelZ      = 1'b0;
  modelC      = 1'b0;
endfunction

function automatic void applyModel(aluPkg::aluOp_e op, logic [addrWidth-1:0] d,
                                   logic [addrWidth-1:0] s1, logic [addrWidth-1:0] s2,
                                   logic [dataWidth-1:0] immV);
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic [dataWidth-1:0] value;
  logic [dataWidth:0]   wide;
  a = modelRegs[s1];
  b = modelRegs[s2];
  case (op)
    aluPkg::opAdd: begin
      wide        = {1'b0, a} + {1'b0, b};
      modelResult = wide[dataWidth-1:0];
      modelZ      = (modelResult == '0);
      modelC      = wide[dataWidth];
    end
    aluPkg::opSub, aluPkg::opCmp: begin
      value  = a - b;
      modelZ = (value == '0);
      modelC = (a >= b);  // No borrow
      if (op == aluPkg::opSub) modelResult = value;
    end
    aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor: begin
      if (op == aluPkg::opAnd) value = a & b;
      else if (op == aluPkg::opOr) value = a | b;
      else value = a ^ b;
      modelResult = value;
      modelZ      = (value == '0);  // Carry stays
    end
    aluPkg::opShl: begin
      modelResult = a << b[2:0];
      modelZ      = (modelResult == '0);
      modelC      = a[dataWidth-1];
    end
    aluPkg::opShr: begin
      modelResult = a >> b[2:0];
      modelZ      = (modelResult == '0);
      modelC      = a[0];
    end
    aluPkg::opLdi: modelResult = immV;
    default: ;  // opNop
  endcase
  if (!(op inside {aluPkg::opCmp, aluPkg::opNop})) modelRegs[d] = modelResult;
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic checkResult(logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp);
  if (got !== exp) failRun($sformatf("[FAIL] result got 'h%0h expected 'h%0h", got, exp));
endtask

task automatic checkFlag(string name, logic got, logic exp);
  if (got !== exp) failRun($sformatf("[FAIL] %s got 'h%0h expected 'h%0h", name, got, exp));
endtask

task automatic checkBusy(logic got, logic exp);
  if (got !== exp) failRun($sformatf("[FAIL] busy got 'h%0h expected 'h%0h", got, exp));
endtask

`endif

//--- tbTop.sv
`timescale 1ns/1ps

module tbTop;

  localparam int dataWidth   = aluPkg::defaultDataWidth;
  localparam int regCount    = aluPkg::defaultRegCount;
  localparam int addrWidth   = $clog2(regCount);
  localparam int clkPeriod   = 8;
  localparam int resetCycles = 16;
  localparam int cmpCount    = 8;
  localparam int randomCount = 500;
  localparam int instrCount  = 2 * regCount + 3 * cmpCount + randomCount;

  logic                 clk;
  logic                 Reset;
  logic                 start;
  aluPkg::aluOp_e       opcode;
  logic [addrWidth-1:0] destin;
  logic [addrWidth-1:0] source1;
  logic [addrWidth-1:0] source2;
  logic [dataWidth-1:0] imm;
  logic                 busy;
  logic                 done;
  logic [dataWidth-1:0] result;
  logic                 zFlag;
  logic                 cFlag;

  int cycle        = 0;
  int failCount    = 0;
  int issuedCount  = 0;
  int checkedCount = 0;

  // Expected responses in issue order
  int                   startEdge [$];
  logic [dataWidth-1:0] expResult [$];
  logic                 expZ [$];
  logic                 expC [$];

  `include "tbModel.svh"

  execCore #(.dataWidth(dataWidth), .regCount(regCount)) uut (
    .clk(clk), .Reset(Reset), .start(start), .opcode(opcode),
    .destin(destin), .source1(source1), .source2(source2), .imm(imm),
    .busy(busy), .done(done), .result(result), .zFlag(zFlag), .cFlag(cFlag)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic failRun(string msg);
    failCount++;
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  // One instruction, optionally with a second start pulse while busy
  task automatic issue(aluPkg::aluOp_e op, logic [addrWidth-1:0] d, logic [addrWidth-1:0] s1,
                       logic [addrWidth-1:0] s2, logic [dataWidth-1:0] immV, bit extraStart);
    opcode  = op;
    destin  = d;
    source1 = s1;
    source2 = s2;
    imm     = immV;
    start   = 1'b1;
    applyModel(op, d, s1, s2, immV);
    startEdge.push_back(cycle + 1);  // Sampled on the coming edge
    expResult.push_back(modelResult);
    expZ.push_back(modelZ);
    expC.push_back(modelC);
    issuedCount++;
    @(posedge clk);
    #1;
    if (extraStart) begin
      opcode = randOp();  // Dropped by the DUT and the model
      destin = randAddr();
      imm    = randData();
      @(posedge clk);
      #1;
    end
    start = 1'b0;
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    aluPkg::aluOp_e       op;
    logic [addrWidth-1:0] d;
    logic [addrWidth-1:0] s1;
    logic [addrWidth-1:0] s2;
    logic [dataWidth-1:0] immV;
    Reset   = 1'b1;
    start   = 1'b0;
    opcode  = aluPkg::opNop;
    destin  = '0;
    source1 = '0;
    source2 = '0;
    imm     = '0;
    resetModel();
    repeat (resetCycles) @(posedge clk);
    #1;
    Reset = 1'b0;
    checkBusy(busy, 1'b0);
    checkFlag("done", done, 1'b0);
    checkResult(result, '0);
    checkFlag("zFlag", zFlag, 1'b0);
    checkFlag("cFlag", cFlag, 1'b0);

    for (int r = 0; r < regCount; r++) begin
      issue(aluPkg::opLdi, addrWidth'(r), '0, '0, randData(), 1'b0);
    end
    for (int r = 0; r < regCount; r++) begin
      issue(aluPkg::opAdd, addrWidth'(r), addrWidth'(r), addrWidth'(r), '0, 1'b0);  // Doubles
    end

    // Compare then read its destination back
    for (int i = 0; i < cmpCount; i++) begin
      d  = randAddr();
      s1 = randAddr();
      s2 = (i % 2 == 0) ? s1 : randAddr();  // Equal sources give Z and C
      issue(aluPkg::opAdd, randAddr(), s1, s2, '0, 1'b0);
      issue(aluPkg::opCmp, d, s1, s2, '0, 1'b0);
      issue(aluPkg::opAdd, randAddr(), d, d, '0, 1'b0);
    end

    for (int i = 0; i < randomCount; i++) begin
      op   = randOp();
      d    = randAddr();
      s1   = randAddr();
      s2   = randAddr();
      immV = randData();
      issue(op, d, s1, s2, immV, (i % 8) == 7);
    end

    wait (checkedCount == issuedCount);
    if (failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Checker
  ////////////////////////////////////////

  initial begin
    int startAt;
    forever begin
      @(negedge clk);
      if (done) begin
        if (expResult.size() == 0) failRun("done pulsed with no instruction outstanding");
        startAt = startEdge.pop_front();
        checkResult(result, expResult.pop_front());
        checkFlag("zFlag", zFlag, expZ.pop_front());
        checkFlag("cFlag", cFlag, expC.pop_front());
        if (cycle - startAt != 2) begin
          failRun($sformatf("done came %0d cycles after the start edge, not 2",
                            cycle - startAt));
        end
        checkBusy(busy, 1'b1);
        @(negedge clk);
        checkFlag("done", done, 1'b0);  // Single cycle pulse
        checkBusy(busy, 1'b0);
        checkedCount++;
      end
    end
  end

  // Watchdog
  initial begin
    #((resetCycles + 6 * instrCount) * clkPeriod);
    failRun("Timeout, the instruction stream did not complete in time");
  end

endmodule

//--- tb.f
+incdir+.
aluPkg.sv
operandIf.sv
regFile.sv
arithUnit.sv
logicUnit.sv
resultMerge.sv
execSequencer.sv
execCore.sv
tbTop.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASSTEXT  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
